/* hw/io_defines.svh */
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// Bus and port widths
`define DATA_BITS 32
`define KEY_BITS 4

// Device base addresses
`define TIMER_BASE 32'hFFFFF100
`define KEY_BASE 32'hFFFFF080

// Register offsets from each base
`define TIMER_CNT_OFS 32'd0
`define TIMER_LIM_OFS 32'd4
`define TIMER_CTL_OFS 32'd8
`define KEY_DATA_OFS 32'd0
`define KEY_CTL_OFS 32'd4

// Clock cycles between two key samples
`define KEY_SAMPLE_PERIOD 16

// Interrupt device numbers, timer has top priority
`define INT_NUM_BITS 4
`define INT_NUM_TIMER 4'd1
`define INT_NUM_KEY 4'd2
`define INT_NUM_NONE 4'd15

`endif

/* hw/ioPkg.sv */
`include "io_defines.svh"

package ioPkg;

  // ==================================================
  // Bus side
  // ==================================================

  // One bus cycle, wr and rd are single-cycle strobes
  typedef struct packed {
    logic [`DATA_BITS-1:0] addr;
    logic [`DATA_BITS-1:0] wdata;
    logic                  wr;
    logic                  rd;
  } busReq_t;

  // Answer of one device to the shared bus
  typedef struct packed {
    logic [`DATA_BITS-1:0] rdata;
    logic                  hit;   // address matches one of our registers
    logic                  intr;  // ready and ie both set
  } devRsp_t;

  // ==================================================
  // Device registers
  // ==================================================

  // Control/status word shared by timer and key port
  typedef struct packed {
    logic [26:0] spareHi;
    logic        ie;
    logic [1:0]  spareLo;
    logic        overrun;
    logic        ready;
  } ctrlStatus_t;

endpackage

/* hw/intervalTimer.sv */
`timescale 1ns/1ps
`include "io_defines.svh"

module intervalTimer (
  input  logic           clk,
  input  logic           RESET,
  input  ioPkg::busReq_t bus,
  output ioPkg::devRsp_t rsp
);
  import ioPkg::*;

  logic [`DATA_BITS-1:0] count;
  logic [`DATA_BITS-1:0] limit;
  ctrlStatus_t           ctl;
  logic                  selCnt;
  logic                  selLim;
  logic                  selCtl;
  logic                  expire;

  // Register decode
  assign selCnt = (bus.addr == (`TIMER_BASE + `TIMER_CNT_OFS));
  assign selLim = (bus.addr == (`TIMER_BASE + `TIMER_LIM_OFS));
  assign selCtl = (bus.addr == (`TIMER_BASE + `TIMER_CTL_OFS));

  // A zero limit keeps the timer free running with no events
  assign expire = (limit != '0) && (count == limit);

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      count <= '0;
      limit <= '0;
      ctl   <= '0;
    end else begin
      if (bus.wr && selCnt) begin
        count <= bus.wdata;
      end else if ((bus.wr && selLim) || expire) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end

      if (bus.wr && selLim) begin
        limit <= bus.wdata;
      end

      // Second expiry before software acknowledges is an overrun
      if (expire) begin
        if (ctl.ready) begin
          ctl.overrun <= 1'b1;
        end else begin
          ctl.ready <= 1'b1;
        end
      end

      // Software write wins over a same-cycle expiry
      if (bus.wr && selCtl) begin
        if (!bus.wdata[0]) begin
          ctl.ready <= 1'b0;
        end
        if (!bus.wdata[1]) begin
          ctl.overrun <= 1'b0;
        end
        ctl.ie <= bus.wdata[4];
      end
    end
  end

  always_comb begin
    rsp.hit  = selCnt | selLim | selCtl;
    rsp.intr = ctl.ready & ctl.ie;
    if (selCnt) begin
      rsp.rdata = count;
    end else if (selLim) begin
      rsp.rdata = limit;
    end else if (selCtl) begin
      rsp.rdata = ctl;
    end else begin
      rsp.rdata = '0;
    end
  end

endmodule

/* hw/keyPort.sv */
`timescale 1ns/1ps
`include "io_defines.svh"

module keyPort (
  input  logic                 clk,
  input  logic                 RESET,
  input  ioPkg::busReq_t       bus,
  input  logic [`KEY_BITS-1:0] keyN,
  output ioPkg::devRsp_t       rsp
);
  import ioPkg::*;

  localparam int sampleCntBits = $clog2(`KEY_SAMPLE_PERIOD);

  logic [sampleCntBits-1:0] sampleCnt;
  logic                     sampleTick;
  logic [`KEY_BITS-1:0]     sample;
  logic [`KEY_BITS-1:0]     lastSample;
  logic [`KEY_BITS-1:0]     keyData;
  ctrlStatus_t              ctl;
  logic                     selData;
  logic                     selCtl;
  logic                     newData;

  assign selData = (bus.addr == (`KEY_BASE + `KEY_DATA_OFS));
  assign selCtl  = (bus.addr == (`KEY_BASE + `KEY_CTL_OFS));

  // ==================================================
  // Sampling and debounce
  // ==================================================

  assign sampleTick = (sampleCnt == sampleCntBits'(`KEY_SAMPLE_PERIOD - 1));

  // Two matching samples that differ from the held value
  assign newData = sampleTick && (sample == lastSample) && (sample != keyData);

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      sampleCnt  <= '0;
      sample     <= '0;
      lastSample <= '0;
      keyData    <= '0;
    end else begin
      if (sampleTick) begin
        sampleCnt  <= '0;
        sample     <= ~keyN;
        lastSample <= sample;
      end else begin
        sampleCnt <= sampleCnt + 1'b1;
      end
      if (newData) begin
        keyData <= sample;
      end
    end
  end

  // ==================================================
  // Control/status
  // ==================================================

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      ctl <= '0;
    end else begin
      // Reading the data acknowledges it
      if (bus.rd && selData) begin
        ctl.ready <= 1'b0;
      end
      if (newData) begin
        if (ctl.ready) begin
          ctl.overrun <= 1'b1;
        end else begin
          ctl.ready <= 1'b1;
        end
      end
      if (bus.wr && selCtl) begin
        if (!bus.wdata[1]) begin
          ctl.overrun <= 1'b0;
        end
        ctl.ie <= bus.wdata[4];
      end
    end
  end

  always_comb begin
    rsp.hit  = selData | selCtl;
    rsp.intr = ctl.ready & ctl.ie;
    if (selData) begin
      rsp.rdata = {{(`DATA_BITS - `KEY_BITS){1'b0}}, keyData};
    end else if (selCtl) begin
      rsp.rdata = ctl;
    end else begin
      rsp.rdata = '0;
    end
  end

endmodule

/* hw/ioCombiner.sv */
`timescale 1ns/1ps
`include "io_defines.svh"

module ioCombiner (
  input  logic                     clk,
  input  logic                     RESET,
  input  ioPkg::devRsp_t           timerRsp,
  input  ioPkg::devRsp_t           keyRsp,
  input  logic                     rd,
  output logic [`DATA_BITS-1:0]    rdata,
  output logic                     rdValid,
  output logic                     intReq,
  output logic [`INT_NUM_BITS-1:0] intNum
);

  logic [`DATA_BITS-1:0] rdSel;

  // ==================================================
  // Read data path
  // ==================================================

  // Device address ranges never overlap, unmapped reads give zero
  always_comb begin
    if (timerRsp.hit) begin
      rdSel = timerRsp.rdata;
    end else if (keyRsp.hit) begin
      rdSel = keyRsp.rdata;
    end else begin
      rdSel = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      rdata <= rdSel;
    end
  end

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      rdValid <= 1'b0;
    end else begin
      rdValid <= rd;
    end
  end

  // ==================================================
  // Interrupt priority encoder
  // ==================================================

  assign intReq = timerRsp.intr | keyRsp.intr;

  assign intNum = timerRsp.intr ? `INT_NUM_TIMER :
                  keyRsp.intr   ? `INT_NUM_KEY   :
                                  `INT_NUM_NONE;

endmodule

/* hw/ioTop.sv */
`timescale 1ns/1ps
`include "io_defines.svh"

module ioTop (
  input  logic                     clk,
  input  logic                     RESET,
  input  ioPkg::busReq_t           bus,
  input  logic [`KEY_BITS-1:0]     keyN,
  output logic [`DATA_BITS-1:0]    rdata,
  output logic                     rdValid,
  output logic                     intReq,
  output logic [`INT_NUM_BITS-1:0] intNum
);
  import ioPkg::*;

  devRsp_t timerRsp;
  devRsp_t keyRsp;

  // Both devices watch the same bus and decode their own addresses
  intervalTimer i_timer (
    .clk   (clk),
    .RESET (RESET),
    .bus   (bus),
    .rsp   (timerRsp)
  );

  keyPort i_keys (
    .clk   (clk),
    .RESET (RESET),
    .bus   (bus),
    .keyN  (keyN),
    .rsp   (keyRsp)
  );

  // Read-back mux and interrupt request
  ioCombiner i_combiner (
    .clk      (clk),
    .RESET    (RESET),
    .timerRsp (timerRsp),
    .keyRsp   (keyRsp),
    .rd       (bus.rd),
    .rdata    (rdata),
    .rdValid  (rdValid),
    .intReq   (intReq),
    .intNum   (intNum)
  );

endmodule

/* testbench/ioTop_checker.sv */
`timescale 1ns/1ps
`include "io_defines.svh"

module ioTop_checker (
  input logic                     clk,
  input logic                     RESET,
  input ioPkg::busReq_t           bus,
  input ioPkg::devRsp_t           timerRsp,
  input ioPkg::devRsp_t           keyRsp,
  input logic [`DATA_BITS-1:0]    rdata,
  input logic                     rdValid,
  input logic                     intReq,
  input logic [`INT_NUM_BITS-1:0] intNum
);

  int errCount = 0;

  // Read data is registered once, so valid trails the strobe by one cycle
  rdValidTiming: assert property (@(posedge clk) disable iff (RESET) rdValid == $past(bus.rd))
    else begin
      errCount = errCount + 1;
      $error("rdValid does not follow the read strobe by one cycle");
    end

  intReqOr: assert property (@(posedge clk) disable iff (RESET)
    intReq == (timerRsp.intr || keyRsp.intr))
    else begin
      errCount = errCount + 1;
      $error("intReq is not the OR of the device interrupts");
    end

  // Timer first, then keys, otherwise no device
  intNumTimer: assert property (@(posedge clk) disable iff (RESET)
    timerRsp.intr |-> (intNum == `INT_NUM_TIMER))
    else begin
      errCount = errCount + 1;
      $error("intNum does not name the timer while its interrupt is pending");
    end

  intNumKey: assert property (@(posedge clk) disable iff (RESET)
    (!timerRsp.intr && keyRsp.intr) |-> (intNum == `INT_NUM_KEY))
    else begin
      errCount = errCount + 1;
      $error("intNum does not name the key port when only its interrupt is pending");
    end

  intNumNone: assert property (@(posedge clk) disable iff (RESET)
    (!timerRsp.intr && !keyRsp.intr) |-> (intNum == `INT_NUM_NONE))
    else begin
      errCount = errCount + 1;
      $error("intNum names a device while no interrupt is pending");
    end

  unmappedZero: assert property (@(posedge clk) disable iff (RESET)
    bus.rd && !timerRsp.hit && !keyRsp.hit |=> rdata == '0)
    else begin
      errCount = errCount + 1;
      $error("Read of an unmapped address returned nonzero data");
    end

endmodule

bind ioTop ioTop_checker i_checker (
  .clk(clk), .RESET(RESET), .bus(bus), .timerRsp(timerRsp), .keyRsp(keyRsp),
  .rdata(rdata), .rdValid(rdValid), .intReq(intReq), .intNum(intNum)
);

/* testbench/ioTb.sv */
`timescale 1ns/1ps
`include "io_defines.svh"

module ioTb;
  import ioPkg::*;

  // Two debounce waits of 64 cycles dominate, the rest is margin
  localparam int cycleLimit = 2000;

  logic                     clk;
  logic                     RESET;
  busReq_t                  bus;
  logic [`KEY_BITS-1:0]     keyN;
  logic [`DATA_BITS-1:0]    rdata;
  logic                     rdValid;
  logic                     intReq;
  logic [`INT_NUM_BITS-1:0] intNum;
  logic [31:0]              rngState = 32'h52b5;
  int                       cycleCount = 0;

  ioTop i_dut (.clk(clk), .RESET(RESET), .bus(bus), .keyN(keyN), .rdata(rdata),
               .rdValid(rdValid), .intReq(intReq), .intNum(intNum));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog, also ends the run on a checker failure
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (i_dut.i_checker.errCount != 0) begin
      $display("Simulation failed");
      $fatal(1, "Assertion failure in the bound checker");
    end else if (cycleCount >= cycleLimit) begin
      $display("Simulation failed");
      $fatal(1, "Timeout after %0d cycles", cycleLimit);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // Inputs change 1 ns after the rising edge
  task automatic stepCycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Wrong value in %s", name);
    end
  endtask

  task automatic busWrite(input logic [31:0] addr, input logic [31:0] data);
    bus.addr  = addr;
    bus.wdata = data;
    bus.wr    = 1'b1;
    stepCycles(1);
    bus.wr = 1'b0;
  endtask

  task automatic busRead(input logic [31:0] addr, output logic [31:0] data);
    bus.addr = addr;
    bus.rd   = 1'b1;
    stepCycles(1);
    bus.rd = 1'b0;
    while (!rdValid) begin
      stepCycles(1);
    end
    data = rdata;
  endtask

  // Random nonzero key pattern that differs from the one held now
  task automatic pickKeys(input logic [`KEY_BITS-1:0] avoid,
                          output logic [`KEY_BITS-1:0] pattern);
    pattern = '0;
    while (pattern == '0 || pattern == avoid) begin
      rngState = xorshift32(rngState);
      pattern  = rngState[`KEY_BITS-1:0];
    end
  endtask

  initial begin
    logic [31:0]          value;
    logic [`KEY_BITS-1:0] keys;
    logic [`KEY_BITS-1:0] moreKeys;
    RESET = 1'b1;
    bus   = '0;
    keyN  = '1;
    stepCycles(4);
    RESET = 1'b0;

    busRead(`TIMER_BASE + `TIMER_LIM_OFS, value);
    checkValue("reset timer limit", 32'h0, value);
    busRead(`TIMER_BASE + `TIMER_CTL_OFS, value);
    checkValue("reset timer control", 32'h0, value);
    checkValue("reset intReq", 32'h0, 32'(intReq));
    checkValue("reset intNum", 32'(`INT_NUM_NONE), 32'(intNum));

    // Period is limit+1, a second expiry before the ack sets overrun
    busWrite(`TIMER_BASE + `TIMER_LIM_OFS, 32'd5);
    stepCycles(6);
    busRead(`TIMER_BASE + `TIMER_CTL_OFS, value);
    checkValue("timer ready", 32'h1, value);
    stepCycles(6);
    busRead(`TIMER_BASE + `TIMER_CTL_OFS, value);
    checkValue("timer overrun", 32'h3, value);
    busWrite(`TIMER_BASE + `TIMER_LIM_OFS, 32'd0);
    busWrite(`TIMER_BASE + `TIMER_CTL_OFS, 32'd0);
    busRead(`TIMER_BASE + `TIMER_CTL_OFS, value);
    checkValue("timer clear", 32'h0, value);

    // Debounce needs at most three sample periods
    pickKeys('0, keys);
    keyN = ~keys;
    stepCycles(4 * `KEY_SAMPLE_PERIOD);
    busRead(`KEY_BASE + `KEY_CTL_OFS, value);
    checkValue("key ready", 32'h1, value);
    busRead(`KEY_BASE + `KEY_DATA_OFS, value);
    checkValue("key data", 32'(keys), value);
    busRead(`KEY_BASE + `KEY_CTL_OFS, value);
    checkValue("key ready cleared", 32'h0, value);

    // Key interrupt alone, then the timer wins, then the key again
    busWrite(`KEY_BASE + `KEY_CTL_OFS, 32'h10);
    pickKeys(keys, moreKeys);
    keyN = ~moreKeys;
    stepCycles(4 * `KEY_SAMPLE_PERIOD);
    checkValue("key intNum", 32'(`INT_NUM_KEY), 32'(intNum));
    busWrite(`TIMER_BASE + `TIMER_CTL_OFS, 32'h10);
    busWrite(`TIMER_BASE + `TIMER_LIM_OFS, 32'd3);
    stepCycles(4);
    checkValue("both intReq", 32'h1, 32'(intReq));
    checkValue("both intNum", 32'(`INT_NUM_TIMER), 32'(intNum));
    busWrite(`TIMER_BASE + `TIMER_LIM_OFS, 32'd0);
    busWrite(`TIMER_BASE + `TIMER_CTL_OFS, 32'h10);
    checkValue("timer acked intNum", 32'(`INT_NUM_KEY), 32'(intNum));

    // Nonzero read first so a stale rdata would show
    busRead(`KEY_BASE + `KEY_DATA_OFS, value);
    checkValue("second key data", 32'(moreKeys), value);
    busRead(`TIMER_BASE + 32'd12, value);
    checkValue("unmapped read", 32'h0, value);

    stepCycles(2);
    if (i_dut.i_checker.errCount == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "Checker reported %0d assertion failures", i_dut.i_checker.errCount);
    end
  end

endmodule

/* vlog.f */
+incdir+hw
hw/ioPkg.sv
hw/intervalTimer.sv
hw/keyPort.sv
hw/ioCombiner.sv
hw/ioTop.sv
testbench/ioTop_checker.sv
testbench/ioTb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := ioTb
FILELIST  := vlog.f
# Keep running after a checker $error so the testbench ends the run itself
RUNARGS   := +verilator+error+limit+100

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	obj_dir/V$(TOP) $(RUNARGS)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
